// File: axi_bridge_pkg.sv
package axi_bridge_pkg;

  // vector types with a fixed meaning on both sides of the bridge
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  req_type_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  // cache-side request types
  localparam req_type_t TYPE_BYTE = 3'd0;
  localparam req_type_t TYPE_HALF = 3'd1;
  localparam req_type_t TYPE_WORD = 3'd2;
  localparam req_type_t TYPE_LINE = 3'd4;

  // requester ids on AR and AW
  localparam axi_id_t ID_INST = 4'd0;
  localparam axi_id_t ID_DATA = 4'd1;

  localparam axi_size_t  SIZE_WORD  = 3'd2;
  localparam axi_burst_t BURST_INCR = 2'd1;
  localparam axi_resp_t  RESP_OKAY  = 2'd0;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_t;

endpackage

// File: rd_ctrl.sv
module rd_ctrl #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       wr_busy,
  // instruction side, read only
  input  logic                       inst_rd_req,
  input  axi_bridge_pkg::req_type_t  inst_rd_type,
  input  axi_bridge_pkg::addr_t      inst_rd_addr,
  output logic                       inst_rd_rdy,
  output logic                       inst_ret_valid,
  output logic                       inst_ret_last,
  output axi_bridge_pkg::word_t      inst_ret_data,
  // data side
  input  logic                       data_rd_req,
  input  axi_bridge_pkg::req_type_t  data_rd_type,
  input  axi_bridge_pkg::addr_t      data_rd_addr,
  output logic                       data_rd_rdy,
  output logic                       data_ret_valid,
  output logic                       data_ret_last,
  output axi_bridge_pkg::word_t      data_ret_data,
  // AR channel
  output axi_bridge_pkg::axi_id_t    arid,
  output axi_bridge_pkg::addr_t      araddr,
  output axi_bridge_pkg::axi_len_t   arlen,
  output axi_bridge_pkg::axi_size_t  arsize,
  output axi_bridge_pkg::axi_burst_t arburst,
  output logic                       arvalid,
  input  logic                       arready,
  // R channel
  input  axi_bridge_pkg::axi_id_t    rid,
  input  axi_bridge_pkg::word_t      rdata,
  input  axi_bridge_pkg::axi_resp_t  rresp,
  input  logic                       rlast,
  input  logic                       rvalid,
  output logic                       rready
);
  import axi_bridge_pkg::*;

  rd_state_t state;
  rd_state_t state_nxt;
  logic      idle;
  logic      data_grant;
  logic      inst_grant;
  logic      accept;
  logic      r_fire;
  req_type_t sel_type;

  assign idle = (state == RD_IDLE);

  // data reads go first, but not while a write is still on the bus
  assign data_grant  = idle && data_rd_req && !wr_busy;
  assign inst_grant  = idle && inst_rd_req && !data_grant;
  assign data_rd_rdy = data_grant;
  assign inst_rd_rdy = inst_grant;
  assign accept      = data_grant || inst_grant;
  assign sel_type    = data_grant ? data_rd_type : inst_rd_type;

  assign arvalid = (state == RD_ADDR);
  assign arburst = BURST_INCR;
  assign rready  = (state == RD_DATA);
  assign r_fire  = rvalid && rready;

  always_comb begin
    state_nxt = state;
    case (state)
      RD_IDLE: if (accept) state_nxt = RD_ADDR;
      RD_ADDR: if (arready) state_nxt = RD_DATA;
      RD_DATA: if (r_fire && rlast) state_nxt = RD_IDLE;
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RD_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // AR payload held from acceptance until the handshake
  always_ff @(posedge aclk) begin
    if (accept) begin
      arid   <= data_grant ? ID_DATA : ID_INST;
      araddr <= data_grant ? data_rd_addr : inst_rd_addr;
      if (sel_type == TYPE_LINE) begin
        arlen  <= axi_len_t'(LINE_WORDS - 1);
        arsize <= SIZE_WORD;
      end else begin
        arlen  <= '0;
        arsize <= {1'b0, sel_type[1:0]};
      end
    end
  end

  // route each beat by rid without back-pressure toward the caches
  assign inst_ret_valid = r_fire && (rid == ID_INST);
  assign inst_ret_last  = inst_ret_valid && rlast;
  assign inst_ret_data  = rdata;
  assign data_ret_valid = r_fire && (rid == ID_DATA);
  assign data_ret_last  = data_ret_valid && rlast;
  assign data_ret_data  = rdata;

  ar_stable_a: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> $stable(araddr) && $stable(arid));

  // slave must not answer before the address phase is done
  r_in_data_a: assert property (@(posedge aclk) disable iff (!rst_n)
    rvalid |-> state == RD_DATA);

  r_okay_a: assert property (@(posedge aclk) disable iff (!rst_n)
    r_fire |-> rresp == RESP_OKAY);

endmodule

// File: wr_ctrl.sv
module wr_ctrl #(
  parameter int LINE_WORDS = 4
) (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       wr_req,
  input  axi_bridge_pkg::req_type_t  wr_type,
  input  logic                       last_beat,
  output logic                       wr_rdy,
  output logic                       wr_busy,
  output logic                       load,
  output logic                       beat_ack,
  output logic                       is_line,
  // AW channel
  output axi_bridge_pkg::axi_id_t    awid,
  output axi_bridge_pkg::axi_len_t   awlen,
  output axi_bridge_pkg::axi_size_t  awsize,
  output axi_bridge_pkg::axi_burst_t awburst,
  output logic                       awvalid,
  input  logic                       awready,
  // W channel
  output logic                       wlast,
  output logic                       wvalid,
  input  logic                       wready,
  // B channel
  input  axi_bridge_pkg::axi_id_t    bid,
  input  axi_bridge_pkg::axi_resp_t  bresp,
  input  logic                       bvalid,
  output logic                       bready
);
  import axi_bridge_pkg::*;

  wr_state_t state;
  wr_state_t state_nxt;
  logic      line_q;

  assign wr_rdy  = (state == WR_IDLE);
  assign wr_busy = !wr_rdy;
  assign load    = wr_req && wr_rdy;

  // taken straight from the request while idle, so the counter sees it on load
  assign is_line = wr_rdy ? (wr_type == TYPE_LINE) : line_q;

  assign awid    = ID_DATA;
  assign awburst = BURST_INCR;
  assign awlen   = line_q ? axi_len_t'(LINE_WORDS - 1) : '0;
  assign awvalid = (state == WR_ADDR);

  assign wvalid   = (state == WR_DATA);
  assign wlast    = last_beat;
  assign beat_ack = wvalid && wready;
  assign bready   = (state == WR_RESP);

  always_comb begin
    state_nxt = state;
    case (state)
      WR_IDLE: if (wr_req) state_nxt = WR_ADDR;
      WR_ADDR: if (awready) state_nxt = WR_DATA;
      WR_DATA: if (beat_ack && last_beat) state_nxt = WR_RESP;
      WR_RESP: if (bvalid) state_nxt = WR_IDLE;
      default: state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= WR_IDLE;
      line_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (load) line_q <= (wr_type == TYPE_LINE);
    end
  end

  always_ff @(posedge aclk) begin
    if (load) awsize <= (wr_type == TYPE_LINE) ? SIZE_WORD : {1'b0, wr_type[1:0]};
  end

  // a waiting W beat keeps wvalid and its wlast
  w_hold_a: assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wlast));

  // only one write in flight, so every response belongs to it
  b_resp_a: assert property (@(posedge aclk) disable iff (!rst_n)
    bvalid && bready |-> bid == awid && bresp == RESP_OKAY);

endmodule

// File: beat_counter.sv
module beat_counter #(
  parameter int LINE_WORDS = 4
) (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic                          is_line,
  input  logic                          beat_ack,
  output logic [$clog2(LINE_WORDS)-1:0] beat_idx,
  output logic                          last_beat
);

  logic [$clog2(LINE_WORDS)-1:0] last_idx;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      beat_idx <= '0;
      last_idx <= '0;
    end else if (load) begin
      beat_idx <= '0;
      last_idx <= is_line ? ($clog2(LINE_WORDS))'(LINE_WORDS - 1) : '0;
    end else if (beat_ack) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  assign last_beat = (beat_idx == last_idx);

  // after the final beat nothing more may come until the next burst is loaded
  no_overrun_a: assert property (@(posedge aclk) disable iff (!rst_n)
    beat_ack && last_beat |=> !beat_ack until load);

endmodule

// File: wr_line_buf.sv
module wr_line_buf #(
  parameter int LINE_WORDS = 4
) (
  input  logic                                     aclk,
  input  logic                                     rst_n,
  input  logic                                     load,
  input  axi_bridge_pkg::addr_t                    wr_addr,
  input  axi_bridge_pkg::strb_t                    wr_wstrb,
  input  axi_bridge_pkg::word_t [LINE_WORDS-1:0]   wr_data,
  input  logic [$clog2(LINE_WORDS)-1:0]            beat_idx,
  input  logic                                     is_line,
  output axi_bridge_pkg::addr_t                    awaddr,
  output axi_bridge_pkg::word_t                    wdata,
  output axi_bridge_pkg::strb_t                    wstrb
);
  import axi_bridge_pkg::*;

  word_t line_q [LINE_WORDS];
  addr_t addr_q;
  strb_t strb_q;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      strb_q <= '0;
    end else if (load) begin
      addr_q <= wr_addr;
      strb_q <= wr_wstrb;
    end
  end

  // word writes use entry 0 only
  always_ff @(posedge aclk) begin
    if (load) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        line_q[i] <= wr_data[i];
      end
    end
  end

  assign awaddr = addr_q;
  assign wdata  = line_q[beat_idx];
  assign wstrb  = is_line ? '1 : strb_q;

endmodule

// File: axi_bridge.sv
module axi_bridge #(
  parameter int LINE_WORDS = 4
) (
  input  logic                                   aclk,
  input  logic                                   rst_n,
  // instruction read
  input  logic                                   inst_rd_req,
  input  axi_bridge_pkg::req_type_t              inst_rd_type,
  input  axi_bridge_pkg::addr_t                  inst_rd_addr,
  output logic                                   inst_rd_rdy,
  output logic                                   inst_ret_valid,
  output logic                                   inst_ret_last,
  output axi_bridge_pkg::word_t                  inst_ret_data,
  // data read
  input  logic                                   data_rd_req,
  input  axi_bridge_pkg::req_type_t              data_rd_type,
  input  axi_bridge_pkg::addr_t                  data_rd_addr,
  output logic                                   data_rd_rdy,
  output logic                                   data_ret_valid,
  output logic                                   data_ret_last,
  output axi_bridge_pkg::word_t                  data_ret_data,
  // data write
  input  logic                                   data_wr_req,
  input  axi_bridge_pkg::req_type_t              data_wr_type,
  input  axi_bridge_pkg::addr_t                  data_wr_addr,
  input  axi_bridge_pkg::strb_t                  data_wr_wstrb,
  input  axi_bridge_pkg::word_t [LINE_WORDS-1:0] data_wr_data,
  output logic                                   data_wr_rdy,
  // AR
  output axi_bridge_pkg::axi_id_t                arid,
  output axi_bridge_pkg::addr_t                  araddr,
  output axi_bridge_pkg::axi_len_t               arlen,
  output axi_bridge_pkg::axi_size_t              arsize,
  output axi_bridge_pkg::axi_burst_t             arburst,
  output logic                                   arvalid,
  input  logic                                   arready,
  // R
  input  axi_bridge_pkg::axi_id_t                rid,
  input  axi_bridge_pkg::word_t                  rdata,
  input  axi_bridge_pkg::axi_resp_t              rresp,
  input  logic                                   rlast,
  input  logic                                   rvalid,
  output logic                                   rready,
  // AW
  output axi_bridge_pkg::axi_id_t                awid,
  output axi_bridge_pkg::addr_t                  awaddr,
  output axi_bridge_pkg::axi_len_t               awlen,
  output axi_bridge_pkg::axi_size_t              awsize,
  output axi_bridge_pkg::axi_burst_t             awburst,
  output logic                                   awvalid,
  input  logic                                   awready,
  // W
  output axi_bridge_pkg::word_t                  wdata,
  output axi_bridge_pkg::strb_t                  wstrb,
  output logic                                   wlast,
  output logic                                   wvalid,
  input  logic                                   wready,
  // B
  input  axi_bridge_pkg::axi_id_t                bid,
  input  axi_bridge_pkg::axi_resp_t              bresp,
  input  logic                                   bvalid,
  output logic                                   bready
);

  logic                          wr_busy;
  logic                          load;
  logic                          beat_ack;
  logic                          is_line;
  logic                          last_beat;
  logic [$clog2(LINE_WORDS)-1:0] beat_idx;

  rd_ctrl #(.LINE_WORDS(LINE_WORDS)) i_rd_ctrl (
    .aclk, .rst_n, .wr_busy,
    .inst_rd_req, .inst_rd_type, .inst_rd_addr, .inst_rd_rdy,
    .inst_ret_valid, .inst_ret_last, .inst_ret_data,
    .data_rd_req, .data_rd_type, .data_rd_addr, .data_rd_rdy,
    .data_ret_valid, .data_ret_last, .data_ret_data,
    .arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready
  );

  wr_ctrl #(.LINE_WORDS(LINE_WORDS)) i_wr_ctrl (
    .aclk, .rst_n,
    .wr_req  (data_wr_req),
    .wr_type (data_wr_type),
    .last_beat,
    .wr_rdy  (data_wr_rdy),
    .wr_busy, .load, .beat_ack, .is_line,
    .awid, .awlen, .awsize, .awburst, .awvalid, .awready,
    .wlast, .wvalid, .wready,
    .bid, .bresp, .bvalid, .bready
  );

  beat_counter #(.LINE_WORDS(LINE_WORDS)) i_beat_counter (
    .aclk, .rst_n, .load, .is_line, .beat_ack, .beat_idx, .last_beat
  );

  wr_line_buf #(.LINE_WORDS(LINE_WORDS)) i_wr_line_buf (
    .aclk, .rst_n, .load,
    .wr_addr  (data_wr_addr),
    .wr_wstrb (data_wr_wstrb),
    .wr_data  (data_wr_data),
    .beat_idx, .is_line,
    .awaddr, .wdata, .wstrb
  );

endmodule

// File: axi_slave_model.sv
module axi_slave_model #(
  parameter int MEM_WORDS = 1024,
  parameter int SEED      = 0
) (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  axi_bridge_pkg::axi_id_t   arid,
  input  axi_bridge_pkg::addr_t     araddr,
  input  axi_bridge_pkg::axi_len_t  arlen,
  input  logic                      arvalid,
  output logic                      arready,
  output axi_bridge_pkg::axi_id_t   rid,
  output axi_bridge_pkg::word_t     rdata,
  output axi_bridge_pkg::axi_resp_t rresp,
  output logic                      rlast,
  output logic                      rvalid,
  input  logic                      rready,
  input  axi_bridge_pkg::axi_id_t   awid,
  input  axi_bridge_pkg::addr_t     awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axi_bridge_pkg::word_t     wdata,
  input  axi_bridge_pkg::strb_t     wstrb,
  input  logic                      wlast,
  input  logic                      wvalid,
  output logic                      wready,
  output axi_bridge_pkg::axi_id_t   bid,
  output axi_bridge_pkg::axi_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready
);
  import axi_bridge_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  word_t       mem [MEM_WORDS];
  integer      seed;
  logic [31:0] rnd;
  logic        rd_busy;
  logic        wr_busy;
  logic        b_pend;
  addr_t       rd_addr;
  addr_t       wr_addr;
  axi_len_t    rd_left;

  function automatic logic [IDX_W-1:0] word_index(input addr_t a);
    return a[IDX_W+1:2];
  endfunction

  function automatic word_t merge_word(input word_t old_w, input word_t new_w, input strb_t s);
    word_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = s[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return r;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = word_t'(i * 4) ^ 32'h5a5a0000;
    end
  end

  // one draw per cycle and each channel takes its own bits
  always @(posedge aclk) rnd <= $random(seed);

  assign rresp = RESP_OKAY;
  assign bresp = RESP_OKAY;

  always @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rd_busy <= 1'b0;
    end else if (!rd_busy) begin
      if (arvalid && arready) begin
        arready <= 1'b0;
        rd_busy <= 1'b1;
        rd_addr <= araddr;
        rd_left <= arlen;
        rid     <= arid;
      end else begin
        arready <= (rnd[1:0] != 2'b00);
      end
    end else if (rvalid && rready) begin
      rvalid  <= 1'b0;
      rd_busy <= !rlast;
      rd_addr <= rd_addr + 32'd4;
      rd_left <= rd_left - 8'd1;
    end else if (!rvalid && rnd[2]) begin
      rvalid <= 1'b1;
      rdata  <= mem[word_index(rd_addr)];
      rlast  <= (rd_left == 8'd0);
    end
  end

  always @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      wr_busy <= 1'b0;
      b_pend  <= 1'b0;
    end else if (!wr_busy) begin
      if (awvalid && awready) begin
        awready <= 1'b0;
        wr_busy <= 1'b1;
        wr_addr <= awaddr;
        bid     <= awid;
      end else begin
        awready <= (rnd[4:3] != 2'b00);
      end
    end else if (!b_pend) begin
      if (wvalid && wready) begin
        mem[word_index(wr_addr)] <= merge_word(mem[word_index(wr_addr)], wdata, wstrb);
        wr_addr <= wr_addr + 32'd4;
        b_pend  <= wlast;
        wready  <= 1'b0;
      end else begin
        wready <= (rnd[6:5] != 2'b00);
      end
    end else if (bvalid && bready) begin
      bvalid  <= 1'b0;
      b_pend  <= 1'b0;
      wr_busy <= 1'b0;
    end else begin
      bvalid <= bvalid || rnd[7];
    end
  end

endmodule

// File: tb_axi_bridge.sv
module tb_axi_bridge;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_bridge_pkg::*;

  localparam int LINE_WORDS = 4;
  localparam int MEM_WORDS  = 1024;
  localparam int IDX_W      = $clog2(MEM_WORDS);
  localparam int SEED       = 32'hef24c228;
  localparam int TIMEOUT    = 2000;

  logic aclk;
  logic rst_n;
  logic inst_rd_req, inst_rd_rdy, inst_ret_valid, inst_ret_last;
  logic data_rd_req, data_rd_rdy, data_ret_valid, data_ret_last;
  logic data_wr_req, data_wr_rdy;
  req_type_t inst_rd_type, data_rd_type, data_wr_type;
  addr_t inst_rd_addr, data_rd_addr, data_wr_addr, araddr, awaddr;
  word_t inst_ret_data, data_ret_data, rdata, wdata;
  strb_t data_wr_wstrb, wstrb;
  word_t [LINE_WORDS-1:0] data_wr_data;
  axi_id_t arid, rid, awid, bid;
  axi_len_t arlen, awlen;
  axi_size_t arsize, awsize;
  axi_burst_t arburst, awburst;
  axi_resp_t rresp, bresp;
  logic arvalid, arready, rlast, rvalid, rready;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;

  word_t      exp_mem [MEM_WORDS];
  word_t      inst_exp_q[$];
  word_t      data_exp_q[$];
  bit         inst_last_q[$];
  bit         data_last_q[$];
  int         errors, tests_run, tests_failed, test_start_errors;
  int         w_beat_cnt, seen_w_beats;
  axi_id_t    seen_awid;
  axi_len_t   seen_arlen, seen_awlen;
  axi_size_t  seen_arsize, seen_awsize;
  axi_burst_t seen_arburst, seen_awburst;
  bit         timed_out;

  axi_bridge #(.LINE_WORDS(LINE_WORDS)) i_axi_bridge (.*);

  axi_slave_model #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) i_slave (.*);

  always #5 aclk = ~aclk;

  function automatic logic [IDX_W-1:0] word_index(input addr_t a);
    return a[IDX_W+1:2];
  endfunction

  function automatic word_t merge_word(input word_t old_w, input word_t new_w, input strb_t s);
    word_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = s[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
    end
    return r;
  endfunction

  // expected memory as every accepted write left it
  function automatic word_t expected_word(input addr_t a);
    return exp_mem[word_index(a)];
  endfunction

  task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    if (!timed_out) begin
      $display("TIMEOUT at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic compare_beat(input bit data_side, input word_t d, input logic last);
    word_t exp_d;
    bit    exp_last;
    if ((data_side ? data_exp_q.size() : inst_exp_q.size()) == 0) begin
      $display("ERROR at %0t ns: a return beat arrived that no request asked for", $time);
      errors++;
      return;
    end
    if (data_side) begin
      exp_d    = data_exp_q.pop_front();
      exp_last = data_last_q.pop_front();
    end else begin
      exp_d    = inst_exp_q.pop_front();
      exp_last = inst_last_q.pop_front();
    end
    check_value(data_side ? "data ret_data" : "inst ret_data", d, exp_d);
    check_value(data_side ? "data ret_last" : "inst ret_last", 32'(last), 32'(exp_last));
  endtask

  always @(posedge aclk) begin
    if (inst_ret_valid) compare_beat(1'b0, inst_ret_data, inst_ret_last);
    if (data_ret_valid) compare_beat(1'b1, data_ret_data, data_ret_last);
  end

  // AXI side monitor
  always @(posedge aclk) begin
    if (!rst_n) begin
      w_beat_cnt   <= 0;
      seen_w_beats <= 0;
    end else begin
      if (arvalid && arready) begin
        seen_arlen   <= arlen;
        seen_arsize  <= arsize;
        seen_arburst <= arburst;
      end
      if (awvalid && awready) begin
        seen_awid    <= awid;
        seen_awlen   <= awlen;
        seen_awsize  <= awsize;
        seen_awburst <= awburst;
      end
      if (wvalid && wready) begin
        w_beat_cnt <= wlast ? 0 : w_beat_cnt + 1;
        if (wlast) seen_w_beats <= w_beat_cnt + 1;
      end
    end
  end

  task automatic drive_read(input bit data_side, input req_type_t t, input addr_t a);
    if (data_side) begin
      data_rd_req  <= 1'b1;
      data_rd_type <= t;
      data_rd_addr <= a;
    end else begin
      inst_rd_req  <= 1'b1;
      inst_rd_type <= t;
      inst_rd_addr <= a;
    end
  endtask

  task automatic accept_read(input bit data_side, input req_type_t t, input addr_t a);
    int beats;
    beats = (t == TYPE_LINE) ? LINE_WORDS : 1;
    for (int i = 0; i < beats; i++) begin
      if (data_side) begin
        data_exp_q.push_back(expected_word(a + 32'(4 * i)));
        data_last_q.push_back(i == beats - 1);
      end else begin
        inst_exp_q.push_back(expected_word(a + 32'(4 * i)));
        inst_last_q.push_back(i == beats - 1);
      end
    end
    if (data_side) data_rd_req <= 1'b0;
    else inst_rd_req <= 1'b0;
  endtask

  task automatic wait_read_accept(input bit data_side, input req_type_t t, input addr_t a);
    bit done;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done && !timed_out; n++) begin
      @(posedge aclk);
      done = data_side ? data_rd_rdy : inst_rd_rdy;
    end
    if (done) accept_read(data_side, t, a);
    else note_timeout("read request acceptance");
  endtask

  task automatic wait_read_done(input bit data_side);
    bit done;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done && !timed_out; n++) begin
      @(posedge aclk);
      done = data_side ? (data_ret_valid && data_ret_last) : (inst_ret_valid && inst_ret_last);
    end
    if (!done) note_timeout("last read beat");
  endtask

  task automatic do_read(input bit data_side, input req_type_t t, input addr_t a);
    drive_read(data_side, t, a);
    wait_read_accept(data_side, t, a);
    wait_read_done(data_side);
  endtask

  task automatic do_write(input req_type_t t, input addr_t a, input strb_t s,
                          input word_t [LINE_WORDS-1:0] d);
    bit done;
    int words;
    words         = (t == TYPE_LINE) ? LINE_WORDS : 1;
    data_wr_req   <= 1'b1;
    data_wr_type  <= t;
    data_wr_addr  <= a;
    data_wr_wstrb <= s;
    data_wr_data  <= d;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done && !timed_out; n++) begin
      @(posedge aclk);
      done = data_wr_rdy;
    end
    data_wr_req <= 1'b0;
    if (!done) note_timeout("write request acceptance");
    for (int i = 0; i < words; i++) begin
      exp_mem[word_index(a + 32'(4 * i))] = (t == TYPE_LINE) ? d[i] :
          merge_word(exp_mem[word_index(a)], d[0], s);
    end
    // wr_rdy comes back after the B handshake
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done && !timed_out; n++) begin
      @(posedge aclk);
      done = data_wr_rdy;
    end
    if (!done) note_timeout("write response");
  endtask

  task automatic finish_test(input string name);
    @(posedge aclk);
    if (inst_exp_q.size() != 0 || data_exp_q.size() != 0) begin
      $display("ERROR at %0t ns: %s ended with return beats still missing", $time, name);
      errors++;
    end
    tests_run++;
    if (errors != test_start_errors) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: PASS", tests_run, name);
    end
  endtask

  initial begin
    word_t [LINE_WORDS-1:0] line_data;
    aclk = 1'b0;
    rst_n = 1'b0;
    {inst_rd_req, data_rd_req, data_wr_req} = '0;
    {inst_rd_type, data_rd_type, data_wr_type} = '0;
    {inst_rd_addr, data_rd_addr, data_wr_addr} = '0;
    data_wr_wstrb = '0;
    data_wr_data = '0;
    {errors, tests_run, tests_failed} = '0;
    timed_out = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      exp_mem[i] = word_t'(i * 4) ^ 32'h5a5a0000;
    end
    repeat (16) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);

    test_start_errors = errors;
    check_value("arvalid after reset", 32'(arvalid), 32'd0);
    check_value("awvalid after reset", 32'(awvalid), 32'd0);
    check_value("wvalid after reset", 32'(wvalid), 32'd0);
    check_value("rready after reset", 32'(rready), 32'd0);
    check_value("bready after reset", 32'(bready), 32'd0);
    check_value("inst ret_valid after reset", 32'(inst_ret_valid), 32'd0);
    check_value("data ret_valid after reset", 32'(data_ret_valid), 32'd0);
    check_value("wr_rdy after reset", 32'(data_wr_rdy), 32'd1);
    check_value("rd_rdy without request", 32'(inst_rd_rdy || data_rd_rdy), 32'd0);
    finish_test("reset state");

    if (!timed_out) begin
      test_start_errors = errors;
      do_read(1'b0, TYPE_LINE, 32'h0000_0100);
      check_value("arlen of line read", 32'(seen_arlen), LINE_WORDS - 1);
      check_value("arsize of line read", 32'(seen_arsize), 32'(SIZE_WORD));
      check_value("arburst of line read", 32'(seen_arburst), 32'(BURST_INCR));
      finish_test("inst line read");
    end
    if (!timed_out) begin
      test_start_errors = errors;
      do_read(1'b1, TYPE_WORD, 32'h0000_0204);
      check_value("arlen of word read", 32'(seen_arlen), 32'd0);
      check_value("arsize of word read", 32'(seen_arsize), 32'd2);
      finish_test("data word read");
    end
    if (!timed_out) begin
      test_start_errors = errors;
      drive_read(1'b1, TYPE_WORD, 32'h0000_0300);
      drive_read(1'b0, TYPE_LINE, 32'h0000_0340);
      @(posedge aclk);
      check_value("data_rd_rdy when both request", 32'(data_rd_rdy), 32'd1);
      check_value("inst_rd_rdy when both request", 32'(inst_rd_rdy), 32'd0);
      if (data_rd_rdy) accept_read(1'b1, TYPE_WORD, 32'h0000_0300);
      wait_read_done(1'b1);
      wait_read_accept(1'b0, TYPE_LINE, 32'h0000_0340);
      wait_read_done(1'b0);
      finish_test("data before inst");
    end
    if (!timed_out) begin
      test_start_errors = errors;
      for (int i = 0; i < LINE_WORDS; i++) begin
        line_data[i] = 32'hc0de_0000 ^ word_t'(i * 32'h0101_0011);
      end
      // line writes ignore the requester's strobe
      do_write(TYPE_LINE, 32'h0000_0400, 4'h0, line_data);
      check_value("awid of line write", 32'(seen_awid), 32'(ID_DATA));
      check_value("awlen of line write", 32'(seen_awlen), LINE_WORDS - 1);
      check_value("awsize of line write", 32'(seen_awsize), 32'(SIZE_WORD));
      check_value("awburst of line write", 32'(seen_awburst), 32'(BURST_INCR));
      check_value("W beats up to wlast", seen_w_beats, LINE_WORDS);
      do_read(1'b1, TYPE_LINE, 32'h0000_0400);
      finish_test("line write then read");
    end
    if (!timed_out) begin
      test_start_errors = errors;
      line_data[0] = 32'h1122_3344;
      do_write(TYPE_WORD, 32'h0000_0508, 4'b0110, line_data);
      check_value("awsize of word write", 32'(seen_awsize), 32'd2);
      check_value("W beats of word write", seen_w_beats, 32'd1);
      do_read(1'b1, TYPE_WORD, 32'h0000_0508);
      finish_test("strobed word write");
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: axi_bridge.f
axi_bridge_pkg.sv
rd_ctrl.sv
wr_ctrl.sv
beat_counter.sv
wr_line_buf.sv
axi_bridge.sv
axi_slave_model.sv
tb_axi_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_bridge
FILELIST  ?= axi_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "simulation PASS" || (echo "simulation FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
